/* Makefile */
# Verilator simulation of the receive decryption control

TOP = tb_decryptCtrl

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  -f decryptCtrl.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* decryptCtrl.f */
+incdir+.
decryptPkg.sv
decryptKeySearchFsm.sv
decryptFrameFlags.sv
decryptDataRoute.sv
decryptPadCtrl.sv
decryptCtrl.sv
tb_decryptCtrl.sv

/* decryptCtrl.sv */
`timescale 1ns/100ps
`include "decryptCtrl_settings.svh"

module decryptCtrl (
  input  logic                    macCoreRxClk,
  input  logic                    macCoreClkHardRst_n,
  input  logic [`RX_DATA_W-1:0]   rxData,
  input  logic                    rxDataValid,
  input  logic                    encrBufferFull,
  input  logic                    endHeaderDone,
  input  decryptPkg::ksrResultT   ksrResult,
  input  decryptPkg::rxCtrlEvtT   rxCtrlEvt,
  input  decryptPkg::frameInfoT   frameInfo,
  input  decryptPkg::plainOutT    plainOut,
  output logic                    indexSearchTrig,
  output logic                    rxKeySearchIndexTrig,
  output logic [`KEY_INDEX_W-1:0] rxKeySearchIndex,
  output logic                    keyIndexCapture,
  output logic                    rxIndexSearchDone,
  output logic                    nullKeyFound,
  output logic                    rxCryptoKeyValid,
  output logic                    initEncrRxCntrl,
  output logic                    rxDataSelect,
  output logic                    pushRxDataInBuffer,
  output logic [`RX_DATA_W-1:0]   wrDataToEncrBuffer,
  output logic                    decryptCntrlReady,
  output logic                    rxFifoReady,
  output logic                    rxError,
  output logic                    encrRxBufFlush,
  output logic                    encrPadding4BytesFIFOEn,
  output logic                    encrPadding4BytesWriteEn,
  output logic                    encrPadding2BytesFIFOEn
);

  decryptPkg::frameFlagsT frameFlags;
  logic [`CIPHER_W-1:0]   cipherType;
  logic                   padEnNow;

  decryptKeySearchFsm u_decryptKeySearchFsm (
    .macCoreRxClk, .macCoreClkHardRst_n, .ksrResult, .rxCtrlEvt, .frameInfo,
    .frameFlags, .indexSearchTrig, .rxKeySearchIndexTrig, .rxKeySearchIndex,
    .keyIndexCapture, .rxIndexSearchDone, .nullKeyFound, .rxCryptoKeyValid,
    .initEncrRxCntrl, .cipherType
  );

  // Capture strobe fires only in address wait, so it qualifies the error pulse
  decryptFrameFlags u_decryptFrameFlags (
    .macCoreRxClk, .macCoreClkHardRst_n, .rxCtrlEvt, .ksrResult,
    .addrWaitActive (keyIndexCapture),
    .frameFlags
  );

  decryptDataRoute u_decryptDataRoute (
    .macCoreRxClk, .macCoreClkHardRst_n, .rxData, .rxDataValid, .encrBufferFull,
    .rxCtrlEvt, .nullKeyFound, .padEnNow, .rxDataSelect, .pushRxDataInBuffer,
    .wrDataToEncrBuffer, .decryptCntrlReady, .rxFifoReady, .rxError, .encrRxBufFlush
  );

  decryptPadCtrl u_decryptPadCtrl (
    .macCoreRxClk, .macCoreClkHardRst_n, .rxDataSelect, .endHeaderDone, .cipherType,
    .plainOut,
    .discardFrm (rxCtrlEvt.discard),
    .padEnNow, .encrPadding4BytesFIFOEn, .encrPadding4BytesWriteEn,
    .encrPadding2BytesFIFOEn
  );

endmodule

/* decryptCtrl_settings.svh */
`ifndef DECRYPTCTRL_SETTINGS_SVH
`define DECRYPTCTRL_SETTINGS_SVH

// Datapath widths
`define RX_DATA_W      8   // Received byte from the deaggregator
`define KEY_INDEX_W    10  // Key RAM index
`define VLAN_ID_W      4   // VLAN id returned by key search
`define DEF_KEY_ID_W   2   // Default key id from the frame IV
`define CIPHER_W       3   // Cipher type in key RAM

// Cipher codes as stored in the key RAM
`define CIPHER_NONE    3'd0  // No key, frame passes as null key
`define CIPHER_WEP     3'd1
`define CIPHER_TKIP    3'd2
`define CIPHER_CCMP    3'd3

// Bit of the cipher type telling that an extended IV is expected
`define CIPHER_EXT_IV_BIT  1

`endif

/* decryptDataRoute.sv */
`timescale 1ns/100ps
`include "decryptCtrl_settings.svh"

module decryptDataRoute (
  input  logic                    macCoreRxClk,
  input  logic                    macCoreClkHardRst_n,
  input  logic [`RX_DATA_W-1:0]   rxData,
  input  logic                    rxDataValid,
  input  logic                    encrBufferFull,
  input  decryptPkg::rxCtrlEvtT   rxCtrlEvt,
  input  logic                    nullKeyFound,
  input  logic                    padEnNow,           // Padding quadlet this cycle
  output logic                    rxDataSelect,       // Bytes go to crypto path
  output logic                    pushRxDataInBuffer,
  output logic [`RX_DATA_W-1:0]   wrDataToEncrBuffer,
  output logic                    decryptCntrlReady,  // Back-pressure to deaggregator
  output logic                    rxFifoReady,
  output logic                    rxError,
  output logic                    encrRxBufFlush
);

  logic idleQ;     // Idle one cycle late
  logic toErrorQ;  // To-error one cycle late

  ////////////////////////////////////////////////////////////////////////////
  // Data select level
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge macCoreRxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      rxDataSelect <= 1'b0;
    else if (rxCtrlEvt.idle || rxCtrlEvt.decrStatusValid || nullKeyFound ||
             rxCtrlEvt.fifoOverflow)
      rxDataSelect <= 1'b0;
    else if (rxCtrlEvt.acceptProtected && rxCtrlEvt.toFrmBody)
      rxDataSelect <= 1'b1;  // Body of an accepted protected frame
  end

  always_ff @(posedge macCoreRxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      idleQ    <= 1'b1;  // No flush straight out of reset
      toErrorQ <= 1'b0;
    end
    else
    begin
      idleQ    <= rxCtrlEvt.idle;
      toErrorQ <= rxCtrlEvt.toError;
    end
  end

  // Buffer write side
  assign decryptCntrlReady  = rxDataSelect ? !encrBufferFull : 1'b1;
  assign pushRxDataInBuffer = rxDataValid && rxDataSelect && decryptCntrlReady;
  assign wrDataToEncrBuffer = rxData;
  assign rxFifoReady        = rxDataSelect && !padEnNow;  // Hold while padding

  assign rxError        = rxDataSelect && toErrorQ;
  assign encrRxBufFlush = rxDataSelect && rxCtrlEvt.idle && !idleQ;  // Idle rising edge

  // Nothing written into a full buffer
  assert property (@(posedge macCoreRxClk) disable iff (!macCoreClkHardRst_n)
    pushRxDataInBuffer |-> !encrBufferFull);

endmodule

/* decryptFrameFlags.sv */
`timescale 1ns/100ps

module decryptFrameFlags (
  input  logic                    macCoreRxClk,
  input  logic                    macCoreClkHardRst_n,
  input  decryptPkg::rxCtrlEvtT   rxCtrlEvt,
  input  decryptPkg::ksrResultT   ksrResult,
  input  logic                    addrWaitActive,  // FSM in address search wait
  output decryptPkg::frameFlagsT  frameFlags
);

  ////////////////////////////////////////////////////////////////////////////
  // Sticky flags, cleared while the receive controller idles
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge macCoreRxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      frameFlags <= '0;
    else if (rxCtrlEvt.idle)
      frameFlags <= '0;
    else
    begin
      // Header done, body starts
      if (rxCtrlEvt.toFrmBody)
        frameFlags.protHdrValid <= 1'b1;
      if (rxCtrlEvt.extIv)
        frameFlags.extIvValid <= 1'b1;
      // Only an address search miss counts, index search errors do not
      if (ksrResult.error && addrWaitActive)
        frameFlags.ksrAddrError <= 1'b1;
      if (ksrResult.valid)
        frameFlags.keyStorageValid <= 1'b1;  // Some key entry returned
    end
  end

endmodule

/* decryptKeySearchFsm.sv */
`timescale 1ns/100ps
`include "decryptCtrl_settings.svh"

module decryptKeySearchFsm (
  input  logic                      macCoreRxClk,
  input  logic                      macCoreClkHardRst_n,
  input  decryptPkg::ksrResultT     ksrResult,
  input  decryptPkg::rxCtrlEvtT     rxCtrlEvt,
  input  decryptPkg::frameInfoT     frameInfo,
  input  decryptPkg::frameFlagsT    frameFlags,
  output logic                      indexSearchTrig,      // Address search trigger
  output logic                      rxKeySearchIndexTrig, // Index search trigger
  output logic [`KEY_INDEX_W-1:0]   rxKeySearchIndex,
  output logic                      keyIndexCapture,
  output logic                      rxIndexSearchDone,
  output logic                      nullKeyFound,
  output logic                      rxCryptoKeyValid,
  output logic                      initEncrRxCntrl,      // Crypto engine start
  output logic [`CIPHER_W-1:0]      cipherType            // Cipher of current frame
);

  decryptPkg::decryptStateT state;
  decryptPkg::decryptStateT nextState;
  logic ivReady;     // IV end seen or header already past
  logic addrErrExt;  // Unknown address with extended IV
  logic extIvSeen;

  assign extIvSeen  = frameFlags.extIvValid || rxCtrlEvt.extIv;
  assign ivReady    = rxCtrlEvt.ivEnd || frameFlags.protHdrValid;
  assign addrErrExt = frameFlags.ksrAddrError && extIvSeen;

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge macCoreRxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      state <= decryptPkg::IDLE;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = state;
    case (state)
      decryptPkg::IDLE:
        if (frameInfo.myFrame || frameInfo.unknownFrame)
          nextState = decryptPkg::KSR_TRIG_WITH_ADDR;
      decryptPkg::KSR_TRIG_WITH_ADDR:
        nextState = decryptPkg::KSR_ADDR_WAIT;
      decryptPkg::KSR_ADDR_WAIT:
        // Default or group key, or no station entry on a data frame
        if (!frameInfo.ctrlFrame && ((ksrResult.valid &&
            (ksrResult.useDefKey || frameInfo.bcMc)) || ksrResult.error))
          nextState = decryptPkg::KSR_TRIG_WITH_INDEX;
        else if (ksrResult.valid || ksrResult.error)
          nextState = decryptPkg::READY_TO_TRIG;
      decryptPkg::KSR_TRIG_WITH_INDEX:
        if (ivReady)
          nextState = addrErrExt ? decryptPkg::IDLE : decryptPkg::KSR_INDEX_WAIT;
      decryptPkg::KSR_INDEX_WAIT:
        if (ksrResult.valid)
          nextState = decryptPkg::READY_TO_TRIG;
      decryptPkg::READY_TO_TRIG:
        if (frameFlags.protHdrValid)
        begin
          if (rxCtrlEvt.acceptProtected && !nullKeyFound &&
              (frameFlags.extIvValid == cipherType[`CIPHER_EXT_IV_BIT]))
            nextState = decryptPkg::ENCR_TRIG;
          else
            nextState = decryptPkg::IDLE;  // Rejected or null key
        end
      decryptPkg::ENCR_TRIG:
        nextState = decryptPkg::IDLE;
      default:
        nextState = decryptPkg::IDLE;
    endcase
    // Abort has priority over every transition
    if (rxCtrlEvt.idle || ((state != decryptPkg::IDLE) && rxCtrlEvt.toError))
      nextState = decryptPkg::IDLE;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Key search triggers
  ////////////////////////////////////////////////////////////////////////////
  assign indexSearchTrig      = (state == decryptPkg::KSR_TRIG_WITH_ADDR);
  assign rxKeySearchIndexTrig = (state == decryptPkg::KSR_TRIG_WITH_INDEX) &&
                                (nextState == decryptPkg::KSR_INDEX_WAIT);
  assign rxKeySearchIndex     = {{(`KEY_INDEX_W-`VLAN_ID_W-`DEF_KEY_ID_W){1'b0}},
                                 ksrResult.vlanId, frameInfo.defKeyId};
  assign keyIndexCapture      = (state == decryptPkg::KSR_ADDR_WAIT) &&
                                (ksrResult.valid || ksrResult.error);
  assign initEncrRxCntrl      = (state == decryptPkg::ENCR_TRIG);

  // Low only while the address search runs
  always_ff @(posedge macCoreRxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      rxIndexSearchDone <= 1'b1;
    else if (rxCtrlEvt.idle)
      rxIndexSearchDone <= 1'b1;
    else if ((state != decryptPkg::KSR_ADDR_WAIT) && (nextState == decryptPkg::KSR_ADDR_WAIT))
      rxIndexSearchDone <= 1'b0;
    else if (keyIndexCapture)
      rxIndexSearchDone <= 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Cipher, null key and key valid
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge macCoreRxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      cipherType <= `CIPHER_NONE;
    else if (rxCtrlEvt.idle)
      cipherType <= `CIPHER_NONE;
    else if (ksrResult.valid)
      cipherType <= ksrResult.cipherType;  // Last search result wins
  end

  always_ff @(posedge macCoreRxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      nullKeyFound <= 1'b0;
    else if (rxCtrlEvt.idle)
      nullKeyFound <= 1'b0;
    else if ((((state == decryptPkg::KSR_INDEX_WAIT) ||
               ((state == decryptPkg::KSR_ADDR_WAIT) && !ksrResult.useDefKey)) &&
              ksrResult.valid && (ksrResult.cipherType == `CIPHER_NONE)) ||
             ((state == decryptPkg::KSR_TRIG_WITH_INDEX) && ivReady && addrErrExt))
      nullKeyFound <= 1'b1;
    else if (frameFlags.protHdrValid && frameFlags.keyStorageValid &&
             (frameFlags.extIvValid != cipherType[`CIPHER_EXT_IV_BIT]))
      nullKeyFound <= 1'b1;  // IV format disagrees with cipher
  end

  always_ff @(posedge macCoreRxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
      rxCryptoKeyValid <= 1'b0;
    else if (rxCtrlEvt.idle || rxCtrlEvt.decrStatusValid)
      rxCryptoKeyValid <= 1'b0;
    else if (nextState == decryptPkg::ENCR_TRIG)
      rxCryptoKeyValid <= 1'b1;
  end

  // State stays inside the encoded set
  assert property (@(posedge macCoreRxClk) disable iff (!macCoreClkHardRst_n)
    state inside {decryptPkg::IDLE, decryptPkg::KSR_TRIG_WITH_INDEX,
                  decryptPkg::KSR_INDEX_WAIT, decryptPkg::KSR_TRIG_WITH_ADDR,
                  decryptPkg::KSR_ADDR_WAIT, decryptPkg::READY_TO_TRIG,
                  decryptPkg::ENCR_TRIG});

  // Engine never started on a null key
  assert property (@(posedge macCoreRxClk) disable iff (!macCoreClkHardRst_n)
    initEncrRxCntrl |-> !nullKeyFound);

endmodule

/* decryptPadCtrl.sv */
`timescale 1ns/100ps
`include "decryptCtrl_settings.svh"

module decryptPadCtrl (
  input  logic                    macCoreRxClk,
  input  logic                    macCoreClkHardRst_n,
  input  logic                    rxDataSelect,
  input  logic                    endHeaderDone,
  input  logic [`CIPHER_W-1:0]    cipherType,
  input  decryptPkg::plainOutT    plainOut,
  input  logic                    discardFrm,
  output logic                    padEnNow,
  output logic                    encrPadding4BytesFIFOEn,
  output logic                    encrPadding4BytesWriteEn,
  output logic                    encrPadding2BytesFIFOEn
);

  logic wepOrTkip;
  logic icvEndNow;
  logic dataEndNow;

  assign wepOrTkip  = (cipherType == `CIPHER_WEP) || (cipherType == `CIPHER_TKIP);
  assign icvEndNow  = plainOut.icvEnd && plainOut.dataValid;
  assign dataEndNow = plainOut.dataEnd && plainOut.dataValid;

  ////////////////////////////////////////////////////////////////////////////
  // Padding condition
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    padEnNow = 1'b0;
    if (rxDataSelect && endHeaderDone)
    begin
      // WEP/TKIP, two quadlets from ICV end
      if (wepOrTkip && (icvEndNow || (encrPadding4BytesFIFOEn && !encrPadding4BytesWriteEn)))
        padEnNow = 1'b1;
      else if ((cipherType == `CIPHER_CCMP) && dataEndNow)
        padEnNow = 1'b1;  // CCMP, one quadlet
    end
  end

  always_ff @(posedge macCoreRxClk or negedge macCoreClkHardRst_n)
  begin
    if (!macCoreClkHardRst_n)
    begin
      encrPadding4BytesFIFOEn  <= 1'b0;
      encrPadding4BytesWriteEn <= 1'b0;
    end
    else if (discardFrm)
    begin
      encrPadding4BytesFIFOEn  <= 1'b0;
      encrPadding4BytesWriteEn <= 1'b0;
    end
    else
    begin
      encrPadding4BytesFIFOEn  <= padEnNow;
      encrPadding4BytesWriteEn <= encrPadding4BytesFIFOEn;  // One cycle behind
    end
  end

  assign encrPadding2BytesFIFOEn = dataEndNow;  // Close last quadlet of body

endmodule

/* decryptPkg.sv */
`include "decryptCtrl_settings.svh"

package decryptPkg;

  // Decryption sequencer states
  typedef enum logic [2:0] {
    IDLE                = 3'd0,
    KSR_TRIG_WITH_INDEX = 3'd1,  // Wait IV end, then index search
    KSR_INDEX_WAIT      = 3'd2,
    KSR_TRIG_WITH_ADDR  = 3'd3,  // One cycle address search trigger
    KSR_ADDR_WAIT       = 3'd4,
    READY_TO_TRIG       = 3'd5,  // Wait protected header
    ENCR_TRIG           = 3'd6
  } decryptStateT;

  // Key search engine return
  typedef struct packed {
    logic                    valid;       // Key found pulse
    logic                    error;       // Address not found pulse
    logic [`CIPHER_W-1:0]    cipherType;
    logic [`VLAN_ID_W-1:0]   vlanId;
    logic                    useDefKey;   // Station uses default key
  } ksrResultT;

  // Receive controller events
  typedef struct packed {
    logic idle;             // Level
    logic toError;          // Pulse
    logic toFrmBody;        // Pulse
    logic ivEnd;            // Pulse
    logic extIv;            // Pulse
    logic decrStatusValid;  // Pulse
    logic acceptProtected;  // Level
    logic discard;          // Level
    logic fifoOverflow;     // Level
  } rxCtrlEvtT;

  // Frame decoder facts
  typedef struct packed {
    logic                      bcMc;         // Broadcast or multicast
    logic                      ctrlFrame;
    logic                      myFrame;      // Pulse
    logic                      unknownFrame; // Pulse
    logic [`DEF_KEY_ID_W-1:0]  defKeyId;
  } frameInfoT;

  // Sticky per-frame flags
  typedef struct packed {
    logic protHdrValid;
    logic extIvValid;
    logic ksrAddrError;
    logic keyStorageValid;
  } frameFlagsT;

  // Crypto engine output strobes
  typedef struct packed {
    logic dataValid;
    logic dataEnd;   // Pulse
    logic icvEnd;    // Pulse
  } plainOutT;

endpackage

/* tb_decryptCtrl.sv */
`timescale 1ns/100ps
`include "decryptCtrl_settings.svh"

module tb_decryptCtrl;

  localparam int FRAMES    = 300;
  localparam int FRAME_LEN = 48;     // Cycles per frame, idle gap included
  localparam int TIMEOUT   = 20000;  // 300 frames of at most 60 cycles, plus margin

  logic macCoreRxClk;
  logic macCoreClkHardRst_n;
  logic [`RX_DATA_W-1:0] rxData;
  logic rxDataValid, encrBufferFull, endHeaderDone;
  decryptPkg::ksrResultT ksrResult;
  decryptPkg::rxCtrlEvtT rxCtrlEvt;
  decryptPkg::frameInfoT frameInfo;
  decryptPkg::plainOutT  plainOut;
  logic indexSearchTrig, rxKeySearchIndexTrig, keyIndexCapture, rxIndexSearchDone;
  logic nullKeyFound, rxCryptoKeyValid, initEncrRxCntrl, rxDataSelect, pushRxDataInBuffer;
  logic decryptCntrlReady, rxFifoReady, rxError, encrRxBufFlush;
  logic encrPadding4BytesFIFOEn, encrPadding4BytesWriteEn, encrPadding2BytesFIFOEn;
  logic [`KEY_INDEX_W-1:0] rxKeySearchIndex;
  logic [`RX_DATA_W-1:0]   wrDataToEncrBuffer;

  // Reference model
  decryptPkg::decryptStateT mSt, mNxt;
  logic mProtHdr, mExtIv, mAddrErr, mKeyStor;  // Sticky frame flags
  logic mIdxDone, mNull, mKeyValid, mSel, mIdleQ, mToErrQ, mFifoEn, mWrEn;
  logic mFound, mIvRdy, mAddrErrExt, mPadNow;
  logic [`CIPHER_W-1:0] mCipher;
  logic [16:0] expKsr, expRoute, expPad;

  // Frame parameters
  logic [`CIPHER_W-1:0] fCipher, fIdxCipher;
  logic fError, fUseDef, fBcMc, fCtrl, fExtIv, fAccept, fUnknown, fAbort, fDiscard;
  logic fOverflow, fFullHeavy;
  logic [`VLAN_ID_W-1:0]    fVlan;
  logic [`DEF_KEY_ID_W-1:0] fDefKey;
  int fAddrAt, fIdxAt, fAbortAt;           // Cycle of address result, index result, abort
  logic [31:0] lcgState;
  int cycleCount = 0;

  decryptCtrl u_decryptCtrl (.*);

  initial
  begin
    macCoreRxClk = 1'b0;
    forever #50 macCoreRxClk = ~macCoreRxClk;
  end

  always @(posedge macCoreRxClk)
  begin
    cycleCount++;
    if (cycleCount >= TIMEOUT)
    begin
      $display("Timeout, the run did not end within %0d cycles", TIMEOUT);
      $display("TESTS FAILED");
      $fatal(1, "Simulation timed out");
    end
  end

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  task automatic checkGroup(input string name, input logic [16:0] got,
                            input logic [16:0] exp);
    assert (got === exp)
    else
    begin
      $display("ERR %0d ns: %s outputs %h, expected %h", $time, name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "Output mismatch");
    end
  endtask

  task automatic pickFrame();
    logic [31:0] r;
    r = lcgNext();
    fCipher    = {1'b0, r[31:30]};           // NONE, WEP, TKIP or CCMP
    fIdxCipher = {1'b0, r[29:28]};
    fError     = r[27] & r[26];              // Address miss in one frame of four
    fUseDef    = r[25];
    fBcMc      = r[24] & r[23];
    fCtrl      = (r[22:20] == 3'd0);
    fExtIv     = r[19];
    fAccept    = (r[18:17] != 2'd0);
    fUnknown   = r[16];
    r = lcgNext();
    fVlan      = r[31:28];
    fDefKey    = r[27:26];
    fAbort     = (r[25:23] == 3'd0);
    fDiscard   = (r[22:20] == 3'd0);
    fOverflow  = (r[19:16] == 4'd0);
    fAddrAt    = 6 + int'(r[15:13]);         // Search latency varies
    fIdxAt     = 18 + int'(r[12:11]);
    fAbortAt   = 5 + int'(r[10:6]);
    fFullHeavy = r[5];                       // Buffer full pattern
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One cycle of frame stimulus applied on the rising edge
  ////////////////////////////////////////////////////////////////////////////
  task automatic driveCycle(input int c);
    decryptPkg::rxCtrlEvtT evt;
    decryptPkg::ksrResultT ksr;
    decryptPkg::frameInfoT fi;
    decryptPkg::plainOutT  po;
    logic [31:0] r;
    r = lcgNext();
    evt = '0;
    evt.idle            = (c < 2);
    evt.toError         = fAbort && (c == fAbortAt);
    evt.ivEnd           = (c == 16);
    evt.extIv           = fExtIv && (c == 16);
    evt.toFrmBody       = (c == 24);
    evt.decrStatusValid = !fAbort && (c == 44);  // Aborted frames end on idle
    evt.acceptProtected = fAccept;
    evt.discard         = fDiscard && (c == 39);
    evt.fifoOverflow    = fOverflow && (c == 35);
    ksr.valid      = (!fError && (c == fAddrAt)) || (c == fIdxAt);
    ksr.error      = fError && (c == fAddrAt);
    ksr.cipherType = (c == fIdxAt) ? fIdxCipher : fCipher;
    ksr.vlanId     = fVlan;
    ksr.useDefKey  = fUseDef;
    fi.bcMc         = fBcMc;
    fi.ctrlFrame    = fCtrl;
    fi.myFrame      = !fUnknown && (c == 3);
    fi.unknownFrame = fUnknown && (c == 3);
    fi.defKeyId     = fDefKey;
    po.dataValid = (c >= 26) && (c <= 41);
    po.dataEnd   = (c == 38);                    // CCMP pads here
    po.icvEnd    = (c == 40);                    // WEP/TKIP pad here
    @(posedge macCoreRxClk);
    rxCtrlEvt      <= evt;
    ksrResult      <= ksr;
    frameInfo      <= fi;
    plainOut       <= po;
    rxData         <= r[31:24];
    rxDataValid    <= r[23] && (c >= 25);
    encrBufferFull <= fFullHeavy ? r[22] : (r[21:19] == 3'd0);
    endHeaderDone  <= (c >= 25);
  endtask

  initial
  begin
    lcgState = 32'h3e46;
    macCoreClkHardRst_n <= 1'b0;
    rxData         <= '0;
    rxDataValid    <= 1'b0;
    encrBufferFull <= 1'b0;
    endHeaderDone  <= 1'b0;
    ksrResult      <= '0;
    rxCtrlEvt      <= '0;
    frameInfo      <= '0;
    plainOut       <= '0;
    repeat (5) @(posedge macCoreRxClk);
    macCoreClkHardRst_n <= 1'b1;
    for (int f = 0; f < FRAMES; f++)
    begin
      pickFrame();
      for (int c = 0; c < FRAME_LEN; c++)
        driveCycle(c);
    end
    repeat (3) driveCycle(0);  // Trailing idle shows the last flush
    @(posedge macCoreRxClk);
    $display("TESTS PASSED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Cycle model checked on the falling edge where all outputs are stable
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge macCoreRxClk)
  begin
    if (!macCoreClkHardRst_n)
    begin
      mSt = decryptPkg::IDLE;
      {mProtHdr, mExtIv, mAddrErr, mKeyStor} = 4'b0;
      {mNull, mKeyValid, mSel, mToErrQ, mFifoEn, mWrEn} = 6'b0;
      mIdxDone = 1'b1;                         // Done level out of reset
      mIdleQ   = 1'b1;
      mCipher  = `CIPHER_NONE;
    end
    else
    begin
      mFound      = ksrResult.valid || ksrResult.error;
      mIvRdy      = rxCtrlEvt.ivEnd || mProtHdr;
      mAddrErrExt = mAddrErr && (mExtIv || rxCtrlEvt.extIv);
      mNxt = mSt;
      case (mSt)
        decryptPkg::IDLE:
          if (frameInfo.myFrame || frameInfo.unknownFrame)
            mNxt = decryptPkg::KSR_TRIG_WITH_ADDR;
        decryptPkg::KSR_TRIG_WITH_ADDR:
          mNxt = decryptPkg::KSR_ADDR_WAIT;
        decryptPkg::KSR_ADDR_WAIT:
          if (mFound && !frameInfo.ctrlFrame &&
              (ksrResult.error || ksrResult.useDefKey || frameInfo.bcMc))
            mNxt = decryptPkg::KSR_TRIG_WITH_INDEX;  // Group or default key
          else if (mFound)
            mNxt = decryptPkg::READY_TO_TRIG;
        decryptPkg::KSR_TRIG_WITH_INDEX:
          if (mIvRdy)
            mNxt = mAddrErrExt ? decryptPkg::IDLE : decryptPkg::KSR_INDEX_WAIT;
        decryptPkg::KSR_INDEX_WAIT:
          if (ksrResult.valid)
            mNxt = decryptPkg::READY_TO_TRIG;
        decryptPkg::READY_TO_TRIG:
          if (mProtHdr && rxCtrlEvt.acceptProtected && !mNull &&
              (mExtIv == mCipher[`CIPHER_EXT_IV_BIT]))
            mNxt = decryptPkg::ENCR_TRIG;
          else if (mProtHdr)
            mNxt = decryptPkg::IDLE;
        default:
          mNxt = decryptPkg::IDLE;             // Engine start lasts one cycle
      endcase
      if (rxCtrlEvt.idle || (rxCtrlEvt.toError && (mSt != decryptPkg::IDLE)))
        mNxt = decryptPkg::IDLE;
      mPadNow = 1'b0;
      if (mSel && endHeaderDone)
      begin
        if (((mCipher == `CIPHER_WEP) || (mCipher == `CIPHER_TKIP)) &&
            ((plainOut.icvEnd && plainOut.dataValid) || (mFifoEn && !mWrEn)))
          mPadNow = 1'b1;                      // Two ICV quadlets
        else if ((mCipher == `CIPHER_CCMP) && plainOut.dataEnd && plainOut.dataValid)
          mPadNow = 1'b1;
      end
      expKsr = {mSt == decryptPkg::KSR_TRIG_WITH_ADDR,
                (mSt == decryptPkg::KSR_TRIG_WITH_INDEX) &&
                (mNxt == decryptPkg::KSR_INDEX_WAIT),
                {4'd0, ksrResult.vlanId, frameInfo.defKeyId},
                (mSt == decryptPkg::KSR_ADDR_WAIT) && mFound,
                mIdxDone, mNull, mKeyValid, mSt == decryptPkg::ENCR_TRIG};
      expRoute = {3'd0, mSel, rxDataValid && mSel && !encrBufferFull, rxData,
                  mSel ? !encrBufferFull : 1'b1, mSel && !mPadNow, mSel && mToErrQ,
                  mSel && rxCtrlEvt.idle && !mIdleQ};
      expPad = {14'd0, mFifoEn, mWrEn, plainOut.dataEnd && plainOut.dataValid};
      checkGroup("key search", {indexSearchTrig, rxKeySearchIndexTrig, rxKeySearchIndex,
                 keyIndexCapture, rxIndexSearchDone, nullKeyFound, rxCryptoKeyValid,
                 initEncrRxCntrl}, expKsr);
      checkGroup("data route", {3'd0, rxDataSelect, pushRxDataInBuffer, wrDataToEncrBuffer,
                 decryptCntrlReady, rxFifoReady, rxError, encrRxBufFlush}, expRoute);
      checkGroup("padding", {14'd0, encrPadding4BytesFIFOEn, encrPadding4BytesWriteEn,
                 encrPadding2BytesFIFOEn}, expPad);
      // Next state from the old values
      if (rxCtrlEvt.idle || rxCtrlEvt.decrStatusValid || mNull || rxCtrlEvt.fifoOverflow)
        mSel = 1'b0;
      else if (rxCtrlEvt.acceptProtected && rxCtrlEvt.toFrmBody)
        mSel = 1'b1;
      mIdleQ  = rxCtrlEvt.idle;
      mToErrQ = rxCtrlEvt.toError;
      mWrEn   = rxCtrlEvt.discard ? 1'b0 : mFifoEn;
      mFifoEn = rxCtrlEvt.discard ? 1'b0 : mPadNow;
      if (rxCtrlEvt.idle)
        mIdxDone = 1'b1;
      else if ((mSt != decryptPkg::KSR_ADDR_WAIT) && (mNxt == decryptPkg::KSR_ADDR_WAIT))
        mIdxDone = 1'b0;                       // Address search running
      else if ((mSt == decryptPkg::KSR_ADDR_WAIT) && mFound)
        mIdxDone = 1'b1;
      if (rxCtrlEvt.idle || rxCtrlEvt.decrStatusValid)
        mKeyValid = 1'b0;
      else if (mNxt == decryptPkg::ENCR_TRIG)
        mKeyValid = 1'b1;
      if (rxCtrlEvt.idle)
        mNull = 1'b0;
      else if (ksrResult.valid && (ksrResult.cipherType == `CIPHER_NONE) &&
               ((mSt == decryptPkg::KSR_INDEX_WAIT) ||
                ((mSt == decryptPkg::KSR_ADDR_WAIT) && !ksrResult.useDefKey)))
        mNull = 1'b1;                          // Zero cipher
      else if ((mSt == decryptPkg::KSR_TRIG_WITH_INDEX) && mIvRdy && mAddrErrExt)
        mNull = 1'b1;
      else if (mProtHdr && mKeyStor && (mExtIv != mCipher[`CIPHER_EXT_IV_BIT]))
        mNull = 1'b1;                          // IV format mismatch
      if (rxCtrlEvt.idle)
        mCipher = `CIPHER_NONE;
      else if (ksrResult.valid)
        mCipher = ksrResult.cipherType;
      if (rxCtrlEvt.idle)
        {mProtHdr, mExtIv, mAddrErr, mKeyStor} = 4'b0;
      else
      begin
        mProtHdr = mProtHdr || rxCtrlEvt.toFrmBody;
        mExtIv   = mExtIv || rxCtrlEvt.extIv;
        mAddrErr = mAddrErr || (ksrResult.error && (mSt == decryptPkg::KSR_ADDR_WAIT));
        mKeyStor = mKeyStor || ksrResult.valid;
      end
      mSt = mNxt;
    end
  end

endmodule
